// File: Makefile
TOP = lcdDriverTb

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f lcdDriver.f
	./obj_dir/V$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; exit $$status
	! grep -q "FAIL: see errors above" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// File: hdl/frameBuffer.sv
`timescale 1ns/10ps

module frameBuffer
    import lcdPkg::*;
(
    input  logic                  clk,
    input  logic                  rstN,
    input  logic [LINE_W-1:0]     lineA,
    input  logic [LINE_W-1:0]     lineB,
    input  logic                  frameValid,
    input  logic                  frameTake,
    input  logic [CHAR_IDX_W-1:0] charIndex,
    output logic                  frameReady,
    output logic [CHAR_W-1:0]     charCode
);

    logic [LINE_W-1:0] pendA;
    logic [LINE_W-1:0] pendB;
    logic              pendFull;
    logic [LINE_W-1:0] dispA;
    logic [LINE_W-1:0] dispB;

    assign frameReady = !pendFull;

    ////////////////////////////////////////
    // pending slot
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (frameValid && frameReady) begin
            pendA <= lineA;
            pendB <= lineB;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pendFull <= 1'b0;
        end else if (frameValid && frameReady) begin
            pendFull <= 1'b1;
        end else if (frameTake) begin
            pendFull <= 1'b0;
        end
    end

    // display slot, blank until the first frame
    always_ff @(posedge clk) begin
        if (!rstN) begin
            dispA <= {LINE_CHARS{BLANK_CHAR}};
            dispB <= {LINE_CHARS{BLANK_CHAR}};
        end else if (frameTake && pendFull) begin
            dispA <= pendA;
            dispB <= pendB;
        end
    end

    // leftmost char sits in the top byte
    always_comb begin
        logic [LINE_W-1:0]     line;
        logic [LINE_IDX_W-1:0] pos;
        line = charIndex[CHAR_IDX_W-1] ? dispB : dispA;
        pos = charIndex[LINE_IDX_W-1:0];
        charCode = line[(LINE_CHARS - 1 - pos) * CHAR_W +: CHAR_W];
    end

endmodule

// File: hdl/lcdDriver.sv
`timescale 1ns/10ps

module lcdDriver
    import lcdPkg::*;
#(
    parameter int stepCycles = STEP_CYCLES_DEFAULT
) (
    input  logic                clk,
    input  logic                rstN,
    input  logic [LINE_W-1:0]   lineA,
    input  logic [LINE_W-1:0]   lineB,
    input  logic                frameValid,
    output logic                frameReady,
    output logic                lcdE,
    output logic                lcdRs,
    output logic [NIBBLE_W-1:0] lcdData
);

    logic                  stepTick;
    logic                  frameTake;
    logic [CHAR_IDX_W-1:0] charIndex;
    logic [CHAR_W-1:0]     charCode;
    logic                  byteValid;
    logic                  byteReady;
    lcdByte_u              byteData;
    logic                  byteIsChar;
    logic                  nibbleOnly;

    stepTimer #(
        .stepCycles(stepCycles)
    ) i_stepTimer (
        .clk     (clk),
        .rstN    (rstN),
        .stepTick(stepTick)
    );

    frameBuffer i_frameBuffer (
        .clk       (clk),
        .rstN      (rstN),
        .lineA     (lineA),
        .lineB     (lineB),
        .frameValid(frameValid),
        .frameTake (frameTake),
        .charIndex (charIndex),
        .frameReady(frameReady),
        .charCode  (charCode)
    );

    lcdSequencer i_lcdSequencer (
        .clk       (clk),
        .rstN      (rstN),
        .byteReady (byteReady),
        .charCode  (charCode),
        .byteValid (byteValid),
        .byteData  (byteData),
        .byteIsChar(byteIsChar),
        .nibbleOnly(nibbleOnly),
        .frameTake (frameTake),
        .charIndex (charIndex)
    );

    nibbleWriter i_nibbleWriter (
        .clk       (clk),
        .rstN      (rstN),
        .stepTick  (stepTick),
        .byteValid (byteValid),
        .byteData  (byteData),
        .byteIsChar(byteIsChar),
        .nibbleOnly(nibbleOnly),
        .byteReady (byteReady),
        .lcdE      (lcdE),
        .lcdRs     (lcdRs),
        .lcdData   (lcdData)
    );

endmodule

// File: hdl/lcdPkg.sv
package lcdPkg;

    ////////////////////////////////////////
    // widths
    ////////////////////////////////////////
    localparam int NIBBLE_W   = 4;
    localparam int CHAR_W     = 8;
    localparam int LINE_CHARS = 16;
    localparam int LINE_W     = LINE_CHARS * CHAR_W;
    localparam int CHAR_IDX_W = 5;
    localparam int LINE_IDX_W = 4;

    // clocks per bus step, 1 ms at 100 MHz
    localparam int STEP_CYCLES_DEFAULT = 100000;

    ////////////////////////////////////////
    // power-up and command codes
    ////////////////////////////////////////
    localparam logic [NIBBLE_W-1:0] INIT_NIBBLE_A = 4'h3;
    localparam logic [NIBBLE_W-1:0] INIT_NIBBLE_B = 4'h2;
    localparam int INIT_NIBBLES = 4;
    localparam int CONFIG_CMDS  = 4;

    localparam logic [CHAR_W-1:0] CMD_FUNCTION_SET = 8'h28;
    localparam logic [CHAR_W-1:0] CMD_ENTRY_MODE   = 8'h06;
    localparam logic [CHAR_W-1:0] CMD_DISPLAY_ON   = 8'h0C;
    localparam logic [CHAR_W-1:0] CMD_CLEAR        = 8'h01;
    localparam logic [CHAR_W-1:0] CMD_LINE_A_ADDR  = 8'h80;
    localparam logic [CHAR_W-1:0] CMD_LINE_B_ADDR  = 8'hC0;
    localparam logic [CHAR_W-1:0] BLANK_CHAR       = 8'h20;

    // sequencer phases
    localparam int PHASE_W = 3;
    localparam logic [PHASE_W-1:0] PH_INIT    = 3'd0;
    localparam logic [PHASE_W-1:0] PH_CONFIG  = 3'd1;
    localparam logic [PHASE_W-1:0] PH_ADDR_A  = 3'd2;
    localparam logic [PHASE_W-1:0] PH_CHARS_A = 3'd3;
    localparam logic [PHASE_W-1:0] PH_ADDR_B  = 3'd4;
    localparam logic [PHASE_W-1:0] PH_CHARS_B = 3'd5;

    // one bus byte, whole or as the two nibbles sent high first
    typedef union packed {
        logic [CHAR_W-1:0] whole;
        struct packed {
            logic [NIBBLE_W-1:0] hi;
            logic [NIBBLE_W-1:0] lo;
        } nib;
    } lcdByte_u;

endpackage

// File: hdl/lcdSequencer.sv
`timescale 1ns/10ps

module lcdSequencer
    import lcdPkg::*;
(
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  byteReady,
    input  logic [CHAR_W-1:0]     charCode,
    output logic                  byteValid,
    output lcdByte_u              byteData,
    output logic                  byteIsChar,
    output logic                  nibbleOnly,
    output logic                  frameTake,
    output logic [CHAR_IDX_W-1:0] charIndex
);

    logic [PHASE_W-1:0]    phase;
    logic [PHASE_W-1:0]    nextPhase;
    logic [LINE_IDX_W-1:0] itemCnt;
    logic                  lastItem;
    logic                  accept;

    assign accept = byteValid && byteReady;

    // line B chars live in the upper half of the index space
    assign charIndex = {(phase == PH_CHARS_B), itemCnt};

    ////////////////////////////////////////
    // phase order
    ////////////////////////////////////////
    always_comb begin
        lastItem = 1'b1;
        nextPhase = PH_ADDR_A;
        case (phase)
            PH_INIT: begin
                lastItem = (itemCnt == LINE_IDX_W'(INIT_NIBBLES - 1));
                nextPhase = PH_CONFIG;
            end
            PH_CONFIG: begin
                lastItem = (itemCnt == LINE_IDX_W'(CONFIG_CMDS - 1));
                nextPhase = PH_ADDR_A;
            end
            PH_ADDR_A: begin
                nextPhase = PH_CHARS_A;
            end
            PH_CHARS_A: begin
                lastItem = (itemCnt == LINE_IDX_W'(LINE_CHARS - 1));
                nextPhase = PH_ADDR_B;
            end
            PH_ADDR_B: begin
                nextPhase = PH_CHARS_B;
            end
            default: begin
                // end of line B wraps back to a fresh refresh
                lastItem = (itemCnt == LINE_IDX_W'(LINE_CHARS - 1));
                nextPhase = PH_ADDR_A;
            end
        endcase
    end

    ////////////////////////////////////////
    // byte request
    ////////////////////////////////////////
    always_comb begin
        byteData.whole = '0;
        byteIsChar = 1'b0;
        nibbleOnly = 1'b0;
        case (phase)
            PH_INIT: begin
                nibbleOnly = 1'b1;
                byteData.nib.hi = lastItem ? INIT_NIBBLE_B : INIT_NIBBLE_A;
                byteData.nib.lo = '0;
            end
            PH_CONFIG: begin
                case (itemCnt)
                    4'd0:    byteData.whole = CMD_FUNCTION_SET;
                    4'd1:    byteData.whole = CMD_ENTRY_MODE;
                    4'd2:    byteData.whole = CMD_DISPLAY_ON;
                    default: byteData.whole = CMD_CLEAR;
                endcase
            end
            PH_ADDR_A: begin
                byteData.whole = CMD_LINE_A_ADDR;
            end
            PH_ADDR_B: begin
                byteData.whole = CMD_LINE_B_ADDR;
            end
            default: begin
                byteIsChar = 1'b1;
                byteData.whole = charCode;
            end
        endcase
    end

    // advance only on a transfer so the request holds under back-pressure
    always_ff @(posedge clk) begin
        if (!rstN) begin
            phase <= PH_INIT;
            itemCnt <= '0;
            byteValid <= 1'b0;
            frameTake <= 1'b0;
        end else begin
            byteValid <= 1'b1;
            frameTake <= 1'b0;
            if (accept) begin
                if (lastItem) begin
                    phase <= nextPhase;
                    itemCnt <= '0;
                    frameTake <= (nextPhase == PH_ADDR_A);
                end else begin
                    itemCnt <= itemCnt + 1'b1;
                end
            end
        end
    end

endmodule

// File: hdl/nibbleWriter.sv
`timescale 1ns/10ps

module nibbleWriter
    import lcdPkg::*;
(
    input  logic                clk,
    input  logic                rstN,
    input  logic                stepTick,
    input  logic                byteValid,
    input  lcdByte_u            byteData,
    input  logic                byteIsChar,
    input  logic                nibbleOnly,
    output logic                byteReady,
    output logic                lcdE,
    output logic                lcdRs,
    output logic [NIBBLE_W-1:0] lcdData
);

    lcdByte_u   dataQ;
    logic       rsQ;
    logic       onlyQ;
    logic       busy;
    logic       lowNib;
    logic [1:0] stepCnt;

    assign byteReady = !busy;

    // unit latch
    always_ff @(posedge clk) begin
        if (byteValid && byteReady) begin
            dataQ <= byteData;
            rsQ <= byteIsChar;
            onlyQ <= nibbleOnly;
        end
    end

    ////////////////////////////////////////
    // three steps per nibble, high first
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rstN) begin
            busy <= 1'b0;
            lowNib <= 1'b0;
            stepCnt <= 2'd0;
            lcdE <= 1'b0;
            lcdRs <= 1'b0;
            lcdData <= '0;
        end else if (!busy) begin
            if (byteValid) begin
                busy <= 1'b1;
                lowNib <= 1'b0;
                stepCnt <= 2'd0;
            end
        end else if (stepTick) begin
            case (stepCnt)
                2'd0: begin
                    lcdE <= 1'b0;
                    stepCnt <= 2'd1;
                end
                2'd1: begin
                    lcdRs <= rsQ;
                    lcdData <= lowNib ? dataQ.nib.lo : dataQ.nib.hi;
                    stepCnt <= 2'd2;
                end
                default: begin
                    // E rises and stays up until the next unit starts
                    lcdE <= 1'b1;
                    stepCnt <= 2'd0;
                    if (lowNib || onlyQ) begin
                        busy <= 1'b0;
                    end else begin
                        lowNib <= 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

// File: hdl/stepTimer.sv
`timescale 1ns/10ps

module stepTimer
    import lcdPkg::*;
#(
    parameter int stepCycles = STEP_CYCLES_DEFAULT
) (
    input  logic clk,
    input  logic rstN,
    output logic stepTick
);

    localparam int CNT_W = (stepCycles > 1) ? $clog2(stepCycles) : 1;

    logic [CNT_W-1:0] count;

    // down-counter, tick on expiry
    always_ff @(posedge clk) begin
        if (!rstN) begin
            count <= CNT_W'(stepCycles - 1);
        end else if (count == '0) begin
            count <= CNT_W'(stepCycles - 1);
        end else begin
            count <= count - 1'b1;
        end
    end

    assign stepTick = (count == '0);

endmodule

// File: lcdDriver.f
hdl/lcdPkg.sv
hdl/stepTimer.sv
hdl/frameBuffer.sv
hdl/lcdSequencer.sv
hdl/nibbleWriter.sv
hdl/lcdDriver.sv
verification/lcdDriver_properties.sv
verification/lcdDriverTb.sv

// File: verification/lcdDriverTb.sv
`timescale 1ns/10ps

module lcdDriverTb
    import lcdPkg::*;
();

    localparam int REFRESH_BYTES = 2 * LINE_CHARS + 2;
    localparam int BYTE_TIMEOUT  = 200;
    localparam int COUNT_TIMEOUT = 5000;
    localparam int READY_TIMEOUT = 2000;
    localparam logic [7:0] CONFIG_EXPECT [4] = '{8'h28, 8'h06, 8'h0C, 8'h01};

    logic                clk;
    logic                rstN;
    logic [LINE_W-1:0]   lineA;
    logic [LINE_W-1:0]   lineB;
    logic                frameValid;
    logic                frameReady;
    logic                lcdE;
    logic                lcdRs;
    logic [NIBBLE_W-1:0] lcdData;

    logic [LINE_W-1:0] frameA [3];
    logic [LINE_W-1:0] frameB [3];
    logic [4:0]        initQ [$];
    logic [8:0]        byteQ [$];
    int                byteCount;
    int                nibbleCount;
    logic              ePrev;
    logic              haveHi;
    logic [3:0]        hiNib;
    bit                compareDone;
    int                seed;
    int                testsDone;
    int                testsFailed;
    int                errorCount;

    lcdDriver #(
        .stepCycles(4)
    ) i_lcdDriver (
        .clk       (clk),
        .rstN      (rstN),
        .lineA     (lineA),
        .lineB     (lineB),
        .frameValid(frameValid),
        .frameReady(frameReady),
        .lcdE      (lcdE),
        .lcdRs     (lcdRs),
        .lcdData   (lcdData)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    ////////////////////////////////////////
    // bus decoder
    ////////////////////////////////////////
    // E rising edges seen on the falling clock edge
    always @(negedge clk) begin
        if (!rstN) begin
            ePrev = 1'b0;
            haveHi = 1'b0;
            nibbleCount = 0;
        end else begin
            if (lcdE && !ePrev) begin
                if (nibbleCount < INIT_NIBBLES) begin
                    initQ.push_back({lcdRs, lcdData});
                end else if (!haveHi) begin
                    hiNib = lcdData;
                    haveHi = 1'b1;
                end else begin
                    byteQ.push_back({lcdRs, hiNib, lcdData});
                    byteCount++;
                    haveHi = 1'b0;
                end
                nibbleCount++;
            end
            ePrev = lcdE;
        end
    end

    // expected {rs, byte} at position pos of one refresh
    function automatic logic [8:0] refreshByte(input logic [LINE_W-1:0] a,
                                               input logic [LINE_W-1:0] b, input int pos);
        if (pos == 0) return {1'b0, 8'h80};
        if (pos <= LINE_CHARS) return {1'b1, a[LINE_W - 8 * pos +: 8]};
        if (pos == LINE_CHARS + 1) return {1'b0, 8'hC0};
        return {1'b1, b[LINE_W - 8 * (pos - LINE_CHARS - 1) +: 8]};
    endfunction

    function automatic int compareItem(input string name, input int idx,
                                       input logic [8:0] expected, input logic [8:0] actual);
        if (actual !== expected) begin
            $display("FAIL %s item %0d: expected rs=%b data=%h, actual rs=%b data=%h",
                     name, idx, expected[8], expected[7:0], actual[8], actual[7:0]);
            errorCount++;
            return 1;
        end
        return 0;
    endfunction

    function automatic void reportTest(input string name, input int errs);
        testsDone++;
        if (errs != 0) testsFailed++;
        $display("test %-12s %0d mismatches", name, errs);
    endfunction

    task automatic timeoutStop(input string what);
        $display("timeout while waiting for %s", what);
        $display("FAIL: see errors above");
        $finish;
    endtask

    task automatic waitForData(input bit wantByte, input string what);
        int cycles;
        cycles = 0;
        while ((wantByte ? byteQ.size() : initQ.size()) == 0) begin
            @(negedge clk);
            cycles++;
            if (cycles > BYTE_TIMEOUT) timeoutStop(what);
        end
    endtask

    task automatic waitByteCount(input int target, input string what);
        int cycles;
        cycles = 0;
        while (byteCount < target) begin
            @(negedge clk);
            cycles++;
            if (cycles > COUNT_TIMEOUT) timeoutStop(what);
        end
    endtask

    // called on a falling edge, returns one edge after the transfer
    task automatic sendFrame(input logic [LINE_W-1:0] a, input logic [LINE_W-1:0] b,
                             input string what, output int countAtTransfer);
        int cycles;
        lineA = a;
        lineB = b;
        frameValid = 1'b1;
        cycles = 0;
        while (frameReady !== 1'b1) begin
            @(negedge clk);
            cycles++;
            if (cycles > READY_TIMEOUT) timeoutStop(what);
        end
        countAtTransfer = byteCount;
        @(negedge clk);
        frameValid = 1'b0;
    endtask

    task automatic checkRefresh(input string name, input logic [LINE_W-1:0] a,
                                input logic [LINE_W-1:0] b);
        int errs;
        logic [8:0] got;
        errs = 0;
        for (int i = 0; i < REFRESH_BYTES; i++) begin
            waitForData(1'b1, {name, " bytes"});
            got = byteQ.pop_front();
            errs += compareItem(name, i, refreshByte(a, b, i), got);
        end
        reportTest(name, errs);
    endtask

    ////////////////////////////////////////
    // comparing process
    ////////////////////////////////////////
    initial begin : compare
        int errs;
        logic [4:0] nib;
        logic [8:0] got;
        errs = 0;
        for (int i = 0; i < INIT_NIBBLES; i++) begin
            waitForData(1'b0, "init nibbles");
            nib = initQ.pop_front();
            errs += compareItem("initNibbles", i,
                                {1'b0, 4'h0, (i < INIT_NIBBLES - 1) ? 4'h3 : 4'h2},
                                {nib[4], 4'h0, nib[3:0]});
        end
        reportTest("initNibbles", errs);
        errs = 0;
        for (int i = 0; i < 4; i++) begin
            waitForData(1'b1, "config bytes");
            got = byteQ.pop_front();
            errs += compareItem("configBytes", i, {1'b0, CONFIG_EXPECT[i]}, got);
        end
        reportTest("configBytes", errs);
        checkRefresh("blankRefresh", {LINE_CHARS{8'h20}}, {LINE_CHARS{8'h20}});
        checkRefresh("frameOne", frameA[0], frameB[0]);
        checkRefresh("frameRepeat", frameA[0], frameB[0]);
        // second frame arrives after refresh four has begun
        checkRefresh("orderFirst", frameA[0], frameB[0]);
        checkRefresh("orderSecond", frameA[1], frameB[1]);
        checkRefresh("orderThird", frameA[2], frameB[2]);
        checkRefresh("orderRepeat", frameA[2], frameB[2]);
        compareDone = 1'b1;
    end

    ////////////////////////////////////////
    // stimulus and end of run
    ////////////////////////////////////////
    initial begin : stimulus
        int errs;
        int transferCount;
        int cycles;
        seed = 32'h027fd466;
        rstN = 1'b0;
        frameValid = 1'b0;
        lineA = '0;
        lineB = '0;
        for (int f = 0; f < 3; f++) begin
            for (int c = 0; c < LINE_CHARS; c++) begin
                frameA[f][c * CHAR_W +: CHAR_W] = CHAR_W'($random(seed));
                frameB[f][c * CHAR_W +: CHAR_W] = CHAR_W'($random(seed));
            end
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        @(negedge clk);
        errs = 0;
        if (lcdE !== 1'b0) begin
            $display("FAIL resetState lcdE: expected 0, actual %b", lcdE);
            errs++;
        end
        if (lcdRs !== 1'b0) begin
            $display("FAIL resetState lcdRs: expected 0, actual %b", lcdRs);
            errs++;
        end
        if (frameReady !== 1'b1) begin
            $display("FAIL resetState frameReady: expected 1, actual %b", frameReady);
            errs++;
        end
        errorCount += errs;
        reportTest("resetState", errs);

        waitByteCount(4, "the config bytes");
        sendFrame(frameA[0], frameB[0], "the first frame", transferCount);
        waitByteCount(4 + 3 * REFRESH_BYTES, "the third refresh");
        sendFrame(frameA[1], frameB[1], "the second frame", transferCount);
        errs = 0;
        if (frameReady !== 1'b0) begin
            $display("FAIL readyHeld frameReady: expected 0, actual %b", frameReady);
            errs++;
        end
        // slot frees only when the next refresh takes the pending frame
        sendFrame(frameA[2], frameB[2], "the third frame", transferCount);
        if ((transferCount - 4) % REFRESH_BYTES != REFRESH_BYTES - 1) begin
            $display("FAIL readyHeld transfer position: expected %0d, actual %0d",
                     REFRESH_BYTES - 1, (transferCount - 4) % REFRESH_BYTES);
            errs++;
        end
        errorCount += errs;
        reportTest("readyHeld", errs);

        cycles = 0;
        while (!compareDone) begin
            @(negedge clk);
            cycles++;
            if (cycles > COUNT_TIMEOUT) timeoutStop("the comparing process");
        end
        $display("%0d tests, %0d failed, %0d mismatches, %0d assertion failures",
                 testsDone, testsFailed, errorCount,
                 i_lcdDriver.i_lcdDriverProperties.assertFails);
        if (testsFailed == 0 && i_lcdDriver.i_lcdDriverProperties.assertFails == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: verification/lcdDriver_properties.sv
`timescale 1ns/10ps

module lcdDriverProperties
    import lcdPkg::*;
(
    input logic                clk,
    input logic                rstN,
    input logic                stepTick,
    input logic                lcdE,
    input logic                lcdRs,
    input logic [NIBBLE_W-1:0] lcdData,
    input logic [LINE_W-1:0]   lineA,
    input logic [LINE_W-1:0]   lineB,
    input logic                frameValid,
    input logic                frameReady
);

    int assertFails = 0;

    // rs and data hold while the panel may latch them
    busStableHigh: assert property (@(posedge clk) disable iff (!rstN)
        lcdE |=> ($stable(lcdRs) && $stable(lcdData)))
    else begin
        $error("lcdRs or lcdData changed while lcdE was high");
        assertFails++;
    end

    // E moves only on step boundaries
    enableOnTick: assert property (@(posedge clk) disable iff (!rstN)
        !$stable(lcdE) |-> $past(stepTick))
    else begin
        $error("lcdE changed without a preceding step tick");
        assertFails++;
    end

    hostHold: assert property (@(posedge clk) disable iff (!rstN)
        (frameValid && !frameReady) |=> ($stable(lineA) && $stable(lineB)))
    else begin
        $error("lineA or lineB changed while a frame was waiting");
        assertFails++;
    end

endmodule

bind lcdDriver lcdDriverProperties i_lcdDriverProperties (
    .clk       (clk),
    .rstN      (rstN),
    .stepTick  (stepTick),
    .lcdE      (lcdE),
    .lcdRs     (lcdRs),
    .lcdData   (lcdData),
    .lineA     (lineA),
    .lineB     (lineB),
    .frameValid(frameValid),
    .frameReady(frameReady)
);
